/* fft_types_pkg.sv */
`default_nettype none

package fft_types_pkg;

    // --------------------
    // Data widths
    // --------------------
    // Complex values travel as separate re/im parts of this type
    typedef logic signed [15:0] sample_t;    // One part, two's complement

    // Sample times twiddle part, also wide enough for butterfly sums
    typedef logic signed [31:0] prod_t;      // Full 16x16 product

    // --------------------
    // Positions
    // --------------------
    typedef logic [3:0] idx_t;               // 0..8 within a frame, 9 as a flag

endpackage

`default_nettype wire

/* fft_sched_pkg.sv */
`default_nettype none

package fft_sched_pkg;

    import fft_types_pkg::*;

    // --------------------
    // Frame geometry
    // --------------------
    localparam int FFT_POINTS  = 9;    // Points per frame
    localparam int STAGE0_SPAN = 3;    // x[n], x[n+3], x[n+6]
    localparam int STAGE1_SPAN = 1;    // Neighbours within a group

    // --------------------
    // Fixed point
    // --------------------
    localparam int      TW_FRAC_BITS = 14;                              // 1.0 = 16384
    localparam prod_t   TW_ROUND     = prod_t'(1) <<< (TW_FRAC_BITS - 1);  // Half an LSB
    localparam sample_t SQRT3_HALF   = 16'sd14189;                      // sqrt(3)/2

    // Real part of W9^k, k = 0..8
    localparam sample_t TW_COS_TABLE [FFT_POINTS] = '{
        16'sd16384, 16'sd12551, 16'sd2845, -16'sd8192, -16'sd15396,
        -16'sd15396, -16'sd8192, 16'sd2845, 16'sd12551
    };

    // Imag part of W9^k, sine already negated
    localparam sample_t TW_SIN_TABLE [FFT_POINTS] = '{
        16'sd0, -16'sd10531, -16'sd16135, -16'sd14189, -16'sd5604,
        16'sd5604, 16'sd14189, 16'sd16135, 16'sd10531
    };

    // --------------------
    // Stage phases
    // --------------------
    typedef enum logic [1:0] {
        PH_IDLE,          // No sample this cycle
        PH_FILL_LONG,     // First third into the long line
        PH_FILL_SHORT,    // Second third into the short line
        PH_BFLY           // Last third, butterfly fires
    } stage_phase_t;

endpackage

`default_nettype wire

/* butterfly3.sv */
`default_nettype none

module butterfly3
    import fft_types_pkg::*;
    import fft_sched_pkg::*;
(
    input  sample_t x0_re,    // Oldest sample of the triple
    input  sample_t x0_im,
    input  sample_t x1_re,    // Middle sample
    input  sample_t x1_im,
    input  sample_t x2_re,    // Newest sample
    input  sample_t x2_im,
    output sample_t y0_re,    // Bin 0, plain sum
    output sample_t y0_im,
    output sample_t y1_re,    // Bin 1, W3 = -1/2 - j*sqrt(3)/2
    output sample_t y1_im,
    output sample_t y2_re,    // Bin 2, conjugate rotation
    output sample_t y2_im
);

    prod_t sum_re;    // x1 + x2
    prod_t sum_im;
    prod_t dif_re;    // x1 - x2
    prod_t dif_im;
    prod_t mid_re;    // x0 - (x1 + x2)/2
    prod_t mid_im;
    prod_t hd_re;     // sqrt(3)/2 * (x1 - x2), rounded
    prod_t hd_im;

    always_comb begin
        sum_re = prod_t'(x1_re) + prod_t'(x2_re);
        sum_im = prod_t'(x1_im) + prod_t'(x2_im);
        dif_re = prod_t'(x1_re) - prod_t'(x2_re);    // Zero when x1 == x2
        dif_im = prod_t'(x1_im) - prod_t'(x2_im);
        mid_re = prod_t'(x0_re) - ((sum_re + prod_t'(1)) >>> 1);    // Exact for even sums
        mid_im = prod_t'(x0_im) - ((sum_im + prod_t'(1)) >>> 1);
        hd_re  = (dif_re * prod_t'(SQRT3_HALF) + TW_ROUND) >>> TW_FRAC_BITS;
        hd_im  = (dif_im * prod_t'(SQRT3_HALF) + TW_ROUND) >>> TW_FRAC_BITS;
    end

    // -j * hd moves the imag part into re, and the other way round
    assign y0_re = sample_t'(prod_t'(x0_re) + sum_re);    // No scaling
    assign y0_im = sample_t'(prod_t'(x0_im) + sum_im);
    assign y1_re = sample_t'(mid_re + hd_im);
    assign y1_im = sample_t'(mid_im - hd_re);
    assign y2_re = sample_t'(mid_re - hd_im);
    assign y2_im = sample_t'(mid_im + hd_re);

endmodule

`default_nettype wire

/* stage_sequencer.sv */
`default_nettype none

module stage_sequencer
    import fft_types_pkg::*;
    import fft_sched_pkg::*;
#(
    parameter int SPAN = 3               // Spacing of butterfly inputs
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_en,          // Sample accepted this cycle
    output stage_phase_t phase,          // Role of the current sample
    output idx_t         drain_sel,      // Cycles since the last butterfly
    output logic         out_start,      // First butterfly cycle of a group
    output logic         out_end         // Last cycle of the output window
);

    idx_t in_cnt;     // Samples already taken in this group
    idx_t out_pos;    // 1..9 while the window is open, 0 when closed

    // --------------------
    // Input side
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_cnt <= '0;
        end else if (!in_en) begin
            in_cnt <= '0;                              // Realign on the idle gap
        end else if (in_cnt == idx_t'(3 * SPAN - 1)) begin
            in_cnt <= '0;                              // Group complete
        end else begin
            in_cnt <= in_cnt + idx_t'(1);
        end
    end

    always_comb begin
        if (!in_en) begin
            phase = PH_IDLE;
        end else if (in_cnt < idx_t'(SPAN)) begin
            phase = PH_FILL_LONG;
        end else if (in_cnt < idx_t'(2 * SPAN)) begin
            phase = PH_FILL_SHORT;
        end else begin
            phase = PH_BFLY;
        end
    end

    assign out_start = (phase == PH_BFLY) && (in_cnt == idx_t'(2 * SPAN));

    // --------------------
    // Output side
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_sel <= idx_t'(2 * SPAN);             // Nothing left to drain
        end else if (phase == PH_BFLY) begin
            drain_sel <= '0;
        end else if (drain_sel != idx_t'(2 * SPAN)) begin
            drain_sel <= drain_sel + idx_t'(1);        // Short line first, then long
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_pos <= '0;
        end else if (out_start && (out_pos == '0 || out_end)) begin
            out_pos <= idx_t'(1);                      // New frame opens the window
        end else if (out_end) begin
            out_pos <= '0;
        end else if (out_pos != '0) begin
            out_pos <= out_pos + idx_t'(1);            // Later groups keep counting
        end
    end

    assign out_end = (out_pos == idx_t'(FFT_POINTS));

    // Input stream stops only on a group boundary
    a_group_whole : assert property (@(posedge clk) disable iff (rst)
        $fell(in_en) |-> in_cnt == '0);

endmodule

`default_nettype wire

/* sdf_stage.sv */
`default_nettype none

module sdf_stage
    import fft_types_pkg::*;
    import fft_sched_pkg::*;
#(
    parameter int SPAN = 3          // 3 for stage 0, 1 for stage 1
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_en,          // Input sample valid
    input  sample_t in_re,
    input  sample_t in_im,
    output logic    out_en,         // Output sample valid
    output sample_t out_re,         // Registered stage output
    output sample_t out_im
);

    stage_phase_t phase;
    idx_t         drain_sel;
    logic         out_start;
    logic         out_end;

    sample_t long_re  [2 * SPAN];    // First third, later y2
    sample_t long_im  [2 * SPAN];
    sample_t short_re [SPAN];        // Second third, later y1
    sample_t short_im [SPAN];
    sample_t long_in_re;
    sample_t long_in_im;
    sample_t short_in_re;
    sample_t short_in_im;
    sample_t y0_re;
    sample_t y0_im;
    sample_t y1_re;
    sample_t y1_im;
    sample_t y2_re;
    sample_t y2_im;
    sample_t sp_re;                  // Single-path output before the register
    sample_t sp_im;

    stage_sequencer #(
        .SPAN      (SPAN)
    ) i_seq (
        .clk       (clk),
        .rst       (rst),
        .in_en     (in_en),
        .phase     (phase),
        .drain_sel (drain_sel),
        .out_start (out_start),
        .out_end   (out_end)
    );

    butterfly3 i_bfly (
        .x0_re (long_re[2 * SPAN - 1]),     // Taken 2*SPAN cycles ago
        .x0_im (long_im[2 * SPAN - 1]),
        .x1_re (short_re[SPAN - 1]),        // Taken SPAN cycles ago
        .x1_im (short_im[SPAN - 1]),
        .x2_re (in_re),                     // Arriving now
        .x2_im (in_im),
        .y0_re (y0_re),
        .y0_im (y0_im),
        .y1_re (y1_re),
        .y1_im (y1_im),
        .y2_re (y2_re),
        .y2_im (y2_im)
    );

    // --------------------
    // Feedback muxes
    // --------------------
    always_comb begin
        long_in_re  = '0;
        long_in_im  = '0;
        short_in_re = '0;
        short_in_im = '0;
        case (phase)
            PH_FILL_LONG: begin
                long_in_re  = in_re;
                long_in_im  = in_im;
            end
            PH_FILL_SHORT: begin
                short_in_re = in_re;
                short_in_im = in_im;
            end
            PH_BFLY: begin
                long_in_re  = y2_re;        // y2 leaves last
                long_in_im  = y2_im;
                short_in_re = y1_re;
                short_in_im = y1_im;
            end
            default: ;
        endcase
    end

    always_comb begin
        if (phase == PH_BFLY) begin
            sp_re = y0_re;                  // y0 goes straight out
            sp_im = y0_im;
        end else if (drain_sel < idx_t'(SPAN)) begin
            sp_re = short_re[SPAN - 1];
            sp_im = short_im[SPAN - 1];
        end else begin
            sp_re = long_re[2 * SPAN - 1];
            sp_im = long_im[2 * SPAN - 1];
        end
    end

    // --------------------
    // Delay lines and output
    // --------------------
    always_ff @(posedge clk) begin
        long_re[0]  <= long_in_re;          // Shift every cycle
        long_im[0]  <= long_in_im;
        short_re[0] <= short_in_re;
        short_im[0] <= short_in_im;
        for (int i = 1; i < 2 * SPAN; i++) begin
            long_re[i] <= long_re[i - 1];
            long_im[i] <= long_im[i - 1];
        end
        for (int i = 1; i < SPAN; i++) begin
            short_re[i] <= short_re[i - 1];
            short_im[i] <= short_im[i - 1];
        end
        out_re <= sp_re;
        out_im <= sp_im;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en <= 1'b0;
        end else if (out_start) begin
            out_en <= 1'b1;
        end else if (out_end) begin
            out_en <= 1'b0;                 // Nine samples sent
        end
    end

    // Each output window lasts exactly nine cycles
    a_out_window : assert property (@(posedge clk) disable iff (rst)
        $fell(out_en) |-> $past(out_en, FFT_POINTS) && !$past(out_en, FFT_POINTS + 1));

endmodule

`default_nettype wire

/* twiddle_rotator.sv */
`default_nettype none

module twiddle_rotator
    import fft_types_pkg::*;
    import fft_sched_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    in_en,        // Stage 0 output valid
    input  sample_t in_re,
    input  sample_t in_im,
    output logic    out_en,       // One cycle behind in_en
    output sample_t out_re,       // Rotated sample
    output sample_t out_im
);

    idx_t    col;       // Position within the group
    idx_t    grp;       // Group within the frame
    idx_t    tw_idx;    // Exponent k of W9^k
    sample_t tw_re;
    sample_t tw_im;
    prod_t   acc_re;
    prod_t   acc_im;

    // --------------------
    // Frame position
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col <= '0;
            grp <= '0;
        end else if (!in_en) begin
            col <= '0;                    // Frames start after a gap
            grp <= '0;
        end else if (col == idx_t'(STAGE0_SPAN - 1)) begin
            col <= '0;
            if (grp == idx_t'(FFT_POINTS / STAGE0_SPAN - 1)) begin
                grp <= '0;
            end else begin
                grp <= grp + idx_t'(1);
            end
        end else begin
            col <= col + idx_t'(1);
        end
    end

    assign tw_idx = grp * col;            // 0, 1, 2 or 4
    assign tw_re  = TW_COS_TABLE[tw_idx];
    assign tw_im  = TW_SIN_TABLE[tw_idx];

    // --------------------
    // Complex multiply
    // --------------------
    always_comb begin
        acc_re = prod_t'(in_re) * prod_t'(tw_re) - prod_t'(in_im) * prod_t'(tw_im);
        acc_im = prod_t'(in_re) * prod_t'(tw_im) + prod_t'(in_im) * prod_t'(tw_re);
        acc_re = (acc_re + TW_ROUND) >>> TW_FRAC_BITS;     // k = 0 passes exactly
        acc_im = (acc_im + TW_ROUND) >>> TW_FRAC_BITS;
    end

    always_ff @(posedge clk) begin
        out_re <= sample_t'(acc_re);
        out_im <= sample_t'(acc_im);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_en <= 1'b0;
        end else begin
            out_en <= in_en;
        end
    end

endmodule

`default_nettype wire

/* fft9_top.sv */
`default_nettype none

module fft9_top
    import fft_types_pkg::*;
    import fft_sched_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    di_en,        // Input sample valid
    input  sample_t di_re,
    input  sample_t di_im,
    input  logic    on,           // Input accepted only while high
    output logic    do_en,        // Output sample valid
    output sample_t do_re,        // Digit-reversed, bin 0 first
    output sample_t do_im
);

    logic    in_en;       // Gated input valid
    logic    sp_en;       // Stage 0 single path
    sample_t sp_re;
    sample_t sp_im;
    logic    rot_en;      // After the twiddle
    sample_t rot_re;
    sample_t rot_im;

    assign in_en = di_en & on;

    // --------------------
    // Stage 0, span 3
    // --------------------
    sdf_stage #(
        .SPAN   (STAGE0_SPAN)
    ) i_stage0 (
        .clk    (clk),
        .rst    (rst),
        .in_en  (in_en),
        .in_re  (di_re),
        .in_im  (di_im),
        .out_en (sp_en),
        .out_re (sp_re),
        .out_im (sp_im)
    );

    twiddle_rotator i_rot (
        .clk    (clk),
        .rst    (rst),
        .in_en  (sp_en),
        .in_re  (sp_re),
        .in_im  (sp_im),
        .out_en (rot_en),
        .out_re (rot_re),
        .out_im (rot_im)
    );

    // --------------------
    // Stage 1, span 1
    // --------------------
    sdf_stage #(
        .SPAN   (STAGE1_SPAN)
    ) i_stage1 (
        .clk    (clk),
        .rst    (rst),
        .in_en  (rot_en),
        .in_re  (rot_re),
        .in_im  (rot_im),
        .out_en (do_en),
        .out_re (do_re),
        .out_im (do_im)
    );

endmodule

`default_nettype wire

/* tb_fft9.sv */
`default_nettype none

module tb_fft9
    import fft_types_pkg::*;
    import fft_sched_pkg::*;
();

    localparam int NUM_TESTS    = 6;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_HALF     = 20;                      // Period 40
    localparam int IN_DLY       = 5;                       // Drive and sample point after the edge
    localparam int AMP_LIMIT    = 3000;                    // 9 * amplitude stays inside 16 bits
    localparam int FRAME_WINDOW = FFT_POINTS + 25;         // Frame plus wait for the last output
    localparam int TEST_CYCLES  = 40;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_TESTS * TEST_CYCLES;

    logic    clk = 1'b0;
    logic    rst;
    logic    di_en;
    logic    on;
    sample_t di_re;
    sample_t di_im;
    logic    do_en;
    sample_t do_re;
    sample_t do_im;

    int seed      = 32'h0baff11b;
    int errors    = 0;
    int passed    = 0;
    int cycle_cnt = 0;

    // --------------------
    // Test table
    // --------------------
    string   test_name [NUM_TESTS];
    logic    test_on   [NUM_TESTS];                        // Level of on during the frame
    sample_t stim_re   [NUM_TESTS][FFT_POINTS];
    sample_t stim_im   [NUM_TESTS][FFT_POINTS];
    sample_t exp_re    [NUM_TESTS][FFT_POINTS];            // Digit-reversed, bin 0 first
    sample_t exp_im    [NUM_TESTS][FFT_POINTS];
    idx_t    exp_count [NUM_TESTS];                        // Expected do_en cycles

    fft9_top i_dut (
        .clk   (clk),
        .rst   (rst),
        .di_en (di_en),
        .di_re (di_re),
        .di_im (di_im),
        .on    (on),
        .do_en (do_en),
        .do_re (do_re),
        .do_im (do_im)
    );

    always #(CLK_HALF) clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic sample_t rand_amp();
        int r;
        r = $random(seed) % AMP_LIMIT;                     // Signed, either polarity
        return sample_t'(r);
    endfunction

    // DC frame, all energy lands in bin 0
    task automatic load_constant(input int t, input string name, input sample_t c_re,
                                 input sample_t c_im, input logic frame_on);
        test_name[t] = name;
        test_on[t]   = frame_on;
        exp_count[t] = frame_on ? idx_t'(FFT_POINTS) : '0;
        for (int n = 0; n < FFT_POINTS; n++) begin
            stim_re[t][n] = c_re;
            stim_im[t][n] = c_im;
            exp_re[t][n]  = (n == 0) ? sample_t'(FFT_POINTS * c_re) : '0;
            exp_im[t][n]  = (n == 0) ? sample_t'(FFT_POINTS * c_im) : '0;
        end
    endtask

    // Impulse at sample 0, flat spectrum
    task automatic load_impulse(input int t, input string name, input sample_t v_re,
                                input sample_t v_im);
        test_name[t] = name;
        test_on[t]   = 1'b1;
        exp_count[t] = idx_t'(FFT_POINTS);
        for (int n = 0; n < FFT_POINTS; n++) begin
            stim_re[t][n] = (n == 0) ? v_re : '0;
            stim_im[t][n] = (n == 0) ? v_im : '0;
            exp_re[t][n]  = v_re;                          // Every bin sees v
            exp_im[t][n]  = v_im;
        end
    endtask

    // --------------------
    // Checks
    // --------------------
    task automatic check_sample(input string sig, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, sig, exp, got);
        end
    endtask

    task automatic check_count(input string sig, input idx_t got, input idx_t exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, sig, exp, got);
        end
    endtask

    task automatic report_failure(input string msg);
        errors = errors + 1;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic tick();
        @(posedge clk);
        #IN_DLY;                                           // Outputs settled, inputs may change
    endtask

    task automatic run_test(input int t);
        int      err_before;
        int      cyc;
        logic    done;
        idx_t    got_count;
        sample_t got_re [FFT_POINTS];
        sample_t got_im [FFT_POINTS];
        err_before = errors;
        cyc        = 0;
        done       = 1'b0;
        got_count  = '0;
        while (!done && cyc < FRAME_WINDOW) begin
            tick();
            if (do_en === 1'b1) begin
                if (got_count < idx_t'(FFT_POINTS)) begin
                    got_re[got_count] = do_re;
                    got_im[got_count] = do_im;
                end
                if (got_count < idx_t'(15)) begin
                    got_count = got_count + idx_t'(1);     // Saturates, never wraps
                end
            end else if (got_count != '0) begin
                done = 1'b1;                               // Output window closed
            end
            if (cyc < FFT_POINTS) begin
                di_en = 1'b1;
                on    = test_on[t];
                di_re = stim_re[t][cyc];
                di_im = stim_im[t][cyc];
            end else begin
                di_en = 1'b0;
                on    = 1'b1;
                di_re = '0;
                di_im = '0;
            end
            cyc = cyc + 1;
        end
        if (test_on[t] && got_count == '0) begin
            report_failure($sformatf("no output appeared for test %s", test_name[t]));
        end else begin
            check_count("do_en cycles", got_count, exp_count[t]);
        end
        for (int n = 0; n < FFT_POINTS; n++) begin
            if (idx_t'(n) < got_count) begin
                check_sample($sformatf("do_re[%0d]", n), got_re[n], exp_re[t][n]);
                check_sample($sformatf("do_im[%0d]", n), got_im[n], exp_im[t][n]);
            end
        end
        repeat (3) begin
            tick();
            if (do_en !== 1'b0) begin
                report_failure("do_en rose again after the output window");
            end
        end
        if (errors == err_before) begin
            passed = passed + 1;
            $display("test %s: ok", test_name[t]);
        end else begin
            $display("test %s: failed with %0d errors", test_name[t], errors - err_before);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst   = 1'b1;
        di_en = 1'b0;
        on    = 1'b0;
        di_re = '0;
        di_im = '0;
        load_constant(0, "zero_frame", '0, '0, 1'b1);
        load_impulse(1, "impulse_a", rand_amp(), rand_amp());
        load_constant(2, "constant_a", rand_amp(), rand_amp(), 1'b1);
        load_constant(3, "on_low", rand_amp(), rand_amp(), 1'b0);  // Gated, nothing out
        load_impulse(4, "impulse_b", rand_amp(), rand_amp());
        load_constant(5, "constant_b", rand_amp(), rand_amp(), 1'b1);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            tick();
            if (do_en !== 1'b0) begin
                report_failure("do_en not low during reset");
            end
        end
        rst = 1'b0;
        on  = 1'b1;
        repeat (4) begin
            tick();
            if (do_en !== 1'b0) begin
                report_failure("do_en high before any frame");
            end
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests %0d, passed %0d, errors %0d", NUM_TESTS, passed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
fft_types_pkg.sv
fft_sched_pkg.sv
butterfly3.sv
stage_sequencer.sv
sdf_stage.sv
twiddle_rotator.sv
fft9_top.sv
tb_fft9.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the 9-point FFT testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_fft9 \
    -Mdir obj_dir -o sim_fft9

./obj_dir/sim_fft9 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
